// ==== rtl/bcd_if.sv ====
////////////////////////////////////////////////////////////////////////////
// four-phase request link from the formatter to the bcd converter
// binary must hold while req is high, bcd holds until req falls
////////////////////////////////////////////////////////////////////////////
interface bcd_if import pulse_meter_pkg::*; ();

	logic req; // requester asks for a conversion
	logic ack; // converter has a result
	count_t binary; // value to convert
	bcd_t bcd; // five packed digits

	// formatter side
	modport requester (
		output req,
		output binary,
		input ack,
		input bcd
	);

	// converter side
	modport converter (
		input req,
		input binary,
		output ack,
		output bcd
	);

endinterface

// ==== rtl/bin_to_bcd.sv ====
////////////////////////////////////////////////////////////////////////////
// sequential double-dabble, one load cycle then one shift per input bit
// ack comes 17 cycles after req is seen, bcd holds until the next load
////////////////////////////////////////////////////////////////////////////
module bin_to_bcd
	import pulse_meter_pkg::*;
(
	input logic clock,
	input logic reset,
	bcd_if.converter conv
);

	logic busy; // shifting in progress
	logic load; // start of a new conversion
	logic [SHIFT_COUNT_WIDTH-1:0] shift_cnt; // shifts done so far
	count_t bin_sr; // binary shift register, msb goes out first
	bcd_t digits; // result being built
	bcd_t digits_adj; // digits after the add-3 step

	// only start when the previous handshake is fully closed
	assign load = conv.req && !conv.ack && !busy;
	assign conv.bcd = digits; // stable after the last shift

	// add 3 to every digit of 5 or more before the shift
	always_comb begin
		digits_adj = digits;
		for (int i = 0; i < DIGITS; i++) begin
			if (digits[4*i +: 4] >= 4'd5) begin
				digits_adj[4*i +: 4] = digits[4*i +: 4] + 4'd3;
			end
		end
	end

	// control and handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			shift_cnt <= '0;
			conv.ack <= 1'b0;
		end else if (load) begin
			busy <= 1'b1;
			shift_cnt <= '0;
		end else if (busy) begin
			shift_cnt <= shift_cnt + 1'b1;
			if (shift_cnt == SHIFT_COUNT_WIDTH'(COUNT_WIDTH - 1)) begin
				busy <= 1'b0; // last shift happens on this edge
				conv.ack <= 1'b1;
			end
		end else if (conv.ack && !conv.req) begin
			conv.ack <= 1'b0; // requester let go
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (load) begin
			bin_sr <= conv.binary;
			digits <= '0;
		end else if (busy) begin
			digits <= {digits_adj[4*DIGITS-2:0], bin_sr[COUNT_WIDTH-1]};
			bin_sr <= bin_sr << 1;
		end
	end

endmodule

// ==== rtl/pulse_meter.sv ====
////////////////////////////////////////////////////////////////////////////
// scaler and tdc on one clock; trigger is asynchronous to it
// outputs update 3 cycles after trigger falls, width saturates at max
// pulses shorter than a clock cycle may be missed
////////////////////////////////////////////////////////////////////////////
module pulse_meter
	import pulse_meter_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic trigger,
	output count_t pulse_count,
	output count_t last_width
);

	// [0] and [1] are the synchronizer, [2] the edge history
	logic [2:0] trig_hist;
	logic trig_sync; // synchronized trigger level
	logic trig_fall; // falling edge seen this cycle
	count_t run_width; // live width of the current pulse

	assign trig_sync = trig_hist[1];
	assign trig_fall = trig_hist[2] && !trig_hist[1]; // 1 then 0

	always_ff @(posedge clock) begin
		if (reset) begin
			trig_hist <= '0;
		end else begin
			trig_hist <= {trig_hist[1:0], trigger}; // shift in the raw input
		end
	end

	// running width, counts only while high
	always_ff @(posedge clock) begin
		if (reset) begin
			run_width <= '0;
		end else if (trig_fall) begin
			run_width <= '0; // pulse over, start again from zero
		end else if (trig_sync && (run_width != '1)) begin
			run_width <= run_width + 1'b1; // stop at all ones
		end
	end

	// cumulative count and last width
	always_ff @(posedge clock) begin
		if (reset) begin
			pulse_count <= '0;
			last_width <= '0;
		end else if (trig_fall) begin
			pulse_count <= pulse_count + 1'b1; // wraps at max
			last_width <= run_width; // both edges delayed alike
		end
	end

	// width check by hand
	// trigger high after edge 0 for W cycles
	// trig_sync is high before edges 3 .. W+2
	// so run_width reaches W just as the fall is seen

endmodule

// ==== rtl/pulse_meter_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// widths, types and timing shared by the pulse meter blocks
// CLKS_PER_BIT is sized for simulation; raise it for a real baud rate
// CLKS_PER_BIT and REPORT_PERIOD must both be 2 or more
////////////////////////////////////////////////////////////////////////////
package pulse_meter_pkg;

	// value widths
	localparam int COUNT_WIDTH = 16; // counts and widths, in clock cycles
	localparam int DIGITS = 5; // 65535 needs five decimal digits
	localparam int SHIFT_COUNT_WIDTH = $clog2(COUNT_WIDTH); // double-dabble steps

	typedef logic [COUNT_WIDTH-1:0] count_t; // pulse count or pulse width
	typedef logic [4*DIGITS-1:0] bcd_t; // packed bcd, most significant digit on top
	typedef logic [7:0] byte_t; // one ascii character

	// uart bit timing
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_COUNT_WIDTH = $clog2(CLKS_PER_BIT);

	// report timer
	localparam int REPORT_PERIOD = 4096; // cycles between timer wraps
	localparam int TIMER_WIDTH = $clog2(REPORT_PERIOD);

	// one report line is digits, space, digits, CR, LF
	localparam int LINE_LENGTH = 2 * DIGITS + 3;
	localparam int CHAR_INDEX_WIDTH = $clog2(LINE_LENGTH);

	// fixed characters
	localparam byte_t ASCII_ZERO = 8'h30; // upper nibble reused for every digit
	localparam byte_t ASCII_SPACE = 8'h20;
	localparam byte_t ASCII_CR = 8'h0d;
	localparam byte_t ASCII_LF = 8'h0a;

endpackage

// ==== rtl/pulse_reporter_top.sv ====
////////////////////////////////////////////////////////////////////////////
// pulse meter with a serial report line, all on one clock
// trigger may be asynchronous, tx idles high
////////////////////////////////////////////////////////////////////////////
module pulse_reporter_top
	import pulse_meter_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic trigger, // pulse input
	output logic tx // uart line out
);

	count_t pulse_count; // cumulative count
	count_t last_width; // width of the most recent pulse
	logic tx_req;
	byte_t tx_byte;
	logic tx_ack;

	bcd_if conv_bus (); // formatter to converter

	pulse_meter pulse_meter_i (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.pulse_count(pulse_count),
		.last_width(last_width)
	);

	bin_to_bcd bin_to_bcd_i (
		.clock(clock),
		.reset(reset),
		.conv(conv_bus.converter)
	);

	report_formatter report_formatter_i (
		.clock(clock),
		.reset(reset),
		.pulse_count(pulse_count),
		.last_width(last_width),
		.conv(conv_bus.requester),
		.tx_req(tx_req),
		.tx_byte(tx_byte),
		.tx_ack(tx_ack)
	);

	uart_tx uart_tx_i (
		.clock(clock),
		.reset(reset),
		.tx_req(tx_req),
		.tx_byte(tx_byte),
		.tx_ack(tx_ack),
		.tx(tx)
	);

endmodule

// ==== rtl/report_formatter.sv ====
////////////////////////////////////////////////////////////////////////////
// sends one ascii line per timer wrap, only if the count has changed
// a wrap during a line is dropped, pulses keep counting meanwhile
// line is count, space, last width, CR, LF, five digits per value
////////////////////////////////////////////////////////////////////////////
module report_formatter
	import pulse_meter_pkg::*;
(
	input logic clock,
	input logic reset,
	input count_t pulse_count,
	input count_t last_width,
	bcd_if.requester conv,
	output logic tx_req,
	output byte_t tx_byte,
	input logic tx_ack
);

	typedef enum logic [2:0] {
		ST_IDLE, // waiting for a timer wrap
		ST_CONV_COUNT,
		ST_CONV_WIDTH,
		ST_SEND_CHAR, // tx_req up until the uart answers
		ST_WAIT_ACK_LOW
	} state_t;

	state_t state;
	logic [TIMER_WIDTH-1:0] timer; // free-running report timer
	logic timer_wrap;
	logic start_line; // new pulses since the last line
	logic conv_done; // converter answered our request
	logic last_char;
	count_t last_count; // count in the last line sent
	count_t snap_count;
	count_t snap_width;
	bcd_t count_bcd;
	bcd_t width_bcd;
	logic [CHAR_INDEX_WIDTH-1:0] char_idx; // character being sent

	assign timer_wrap = (timer == TIMER_WIDTH'(REPORT_PERIOD - 1));
	assign start_line = (state == ST_IDLE) && timer_wrap && (pulse_count != last_count);
	assign conv_done = conv.req && conv.ack;
	assign last_char = (char_idx == CHAR_INDEX_WIDTH'(LINE_LENGTH - 1));
	// mux only switches while req is low
	assign conv.binary = (state == ST_CONV_WIDTH) ? snap_width : snap_count;

	always_ff @(posedge clock) begin
		if (reset || timer_wrap) begin
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			conv.req <= 1'b0;
			tx_req <= 1'b0;
			last_count <= '0;
			char_idx <= '0;
		end else begin
			unique case (state)
				ST_IDLE: begin
					if (start_line) begin
						last_count <= pulse_count;
						char_idx <= '0;
						state <= ST_CONV_COUNT;
					end
				end
				ST_CONV_COUNT, ST_CONV_WIDTH: begin
					if (conv_done) begin
						conv.req <= 1'b0;
						state <= (state == ST_CONV_COUNT) ? ST_CONV_WIDTH : ST_SEND_CHAR;
					end else if (!conv.ack) begin
						conv.req <= 1'b1; // previous ack has dropped
					end
				end
				ST_SEND_CHAR: begin
					if (tx_ack) begin
						tx_req <= 1'b0; // stop bit is out
						state <= ST_WAIT_ACK_LOW;
					end else begin
						tx_req <= 1'b1;
					end
				end
				ST_WAIT_ACK_LOW: begin
					if (!tx_ack) begin
						if (last_char) begin
							state <= ST_IDLE; // line done
						end else begin
							char_idx <= char_idx + 1'b1;
							state <= ST_SEND_CHAR;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// snapshot and conversion results
	always_ff @(posedge clock) begin
		if (start_line) begin
			snap_count <= pulse_count;
			snap_width <= last_width;
		end
		if (conv_done && (state == ST_CONV_COUNT)) count_bcd <= conv.bcd;
		if (conv_done && (state == ST_CONV_WIDTH)) width_bcd <= conv.bcd;
	end

	// character select, digits most significant first
	always_comb begin
		if (char_idx < CHAR_INDEX_WIDTH'(DIGITS)) begin
			tx_byte = {ASCII_ZERO[7:4], count_bcd[4 * (DIGITS - 1 - int'(char_idx)) +: 4]};
		end else if (char_idx == CHAR_INDEX_WIDTH'(DIGITS)) begin
			tx_byte = ASCII_SPACE;
		end else if (char_idx <= CHAR_INDEX_WIDTH'(2 * DIGITS)) begin
			tx_byte = {ASCII_ZERO[7:4], width_bcd[4 * (2 * DIGITS - int'(char_idx)) +: 4]};
		end else if (char_idx == CHAR_INDEX_WIDTH'(2 * DIGITS + 1)) begin
			tx_byte = ASCII_CR;
		end else begin
			tx_byte = ASCII_LF;
		end
	end

endmodule

// ==== rtl/uart_tx.sv ====
////////////////////////////////////////////////////////////////////////////
// 8N1 transmitter, lsb first, CLKS_PER_BIT cycles per bit
// ack comes after the stop bit, 10 bit times after req is seen
////////////////////////////////////////////////////////////////////////////
module uart_tx
	import pulse_meter_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic tx_req,
	input byte_t tx_byte,
	output logic tx_ack,
	output logic tx
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT, // start, data and stop bits
		ST_DONE // ack high, waiting for req to fall
	} state_t;

	state_t state;
	logic [BAUD_COUNT_WIDTH-1:0] baud_cnt; // cycles into the current bit
	logic [3:0] bit_cnt; // bits started, start bit is 0
	logic [8:0] frame; // data then stop bit, shifted out at bit 0
	logic bit_end;

	assign bit_end = (baud_cnt == BAUD_COUNT_WIDTH'(CLKS_PER_BIT - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			tx <= 1'b1; // line idles high
			tx_ack <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			unique case (state)
				ST_IDLE: begin
					if (tx_req) begin
						tx <= 1'b0; // start bit
						baud_cnt <= '0;
						bit_cnt <= '0;
						state <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (!bit_end) begin
						baud_cnt <= baud_cnt + 1'b1;
					end else begin
						baud_cnt <= '0;
						if (bit_cnt == 4'd9) begin
							tx_ack <= 1'b1; // stop bit complete
							state <= ST_DONE;
						end else begin
							tx <= frame[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				ST_DONE: begin
					if (!tx_req) begin
						tx_ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// byte latch and shifter
	always_ff @(posedge clock) begin
		if ((state == ST_IDLE) && tx_req) begin
			frame <= {1'b1, tx_byte};
		end else if ((state == ST_SHIFT) && bit_end) begin
			frame <= {1'b1, frame[8:1]}; // refill with stop level
		end
	end

endmodule

// ==== sim/pulse_reporter_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// directed tests that decode and compare every report line on tx
// report timer phase is tracked from reset release
// the burst fits inside one report period
////////////////////////////////////////////////////////////////////////////
module pulse_reporter_tb
	import pulse_meter_pkg::*;
();

	localparam int LINE_WAIT = 3 * REPORT_PERIOD; // cycles allowed until a line starts
	localparam int CHAR_WAIT = 4 * CLKS_PER_BIT; // gap allowed between characters

	logic clock, reset, trigger, tx;
	int cycle_count; // equals the dut report timer
	int error_count = 0;
	int tests_with_errors = 0;
	logic [31:0] rng_state = 32'h5cd;
	count_t model_count = '0; // expected cumulative count
	count_t model_width = '0; // expected last width

	tb_clock_gen clock_gen_i (.clock(clock), .reset(reset));

	pulse_reporter_top pulse_reporter_top_i (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.tx(tx)
	);

	always @(posedge clock) begin
		if (reset) cycle_count <= 0;
		else cycle_count <= cycle_count + 1; // free running like the timer
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// value in lo .. lo+span-1 taken from the upper lcg bits
	task automatic draw_random(input int lo, input int span, output int value);
		rng_state = lcg_next(rng_state);
		value = lo + int'(rng_state[30:16]) % span;
	endtask

	// high for width cycles and then low for gap cycles
	task automatic send_pulse(input int width, input int gap);
		@(posedge clock);
		trigger <= 1'b1;
		repeat (width) @(posedge clock);
		trigger <= 1'b0;
		repeat (gap) @(posedge clock); // gap of 4 or more lets the count settle
		model_count = model_count + 1'b1; // wraps like the counter
		model_width = count_t'(width);
	endtask

	// ascii character idx of the line for the given values
	function automatic byte_t expected_char(input count_t count, input count_t width, input int idx);
		int value;
		int power;
		power = 1;
		if (idx == DIGITS) return 8'h20; // space
		if (idx == 2 * DIGITS + 1) return 8'h0d;
		if (idx == 2 * DIGITS + 2) return 8'h0a;
		value = (idx < DIGITS) ? int'(count) : int'(width);
		for (int k = idx % (DIGITS + 1); k < DIGITS - 1; k++) power = power * 10;
		return byte_t'(8'h30 + (value / power) % 10); // leading zeros kept
	endfunction

	task automatic wait_tx_low(input int limit, output bit seen);
		int waited;
		waited = 0;
		@(negedge clock);
		while ((tx !== 1'b0) && (waited < limit)) begin
			@(negedge clock);
			waited++;
		end
		seen = (tx === 1'b0);
		assert (seen) else begin
			$display("tx did not go low within %0d cycles, time %0t", limit, $time);
			error_count++;
		end
	endtask

	// one 8N1 character sampled mid bit on the falling edge
	task automatic receive_byte(input int start_wait, output byte_t data, output bit ok);
		data = '0;
		wait_tx_low(start_wait, ok);
		if (ok) begin
			repeat (CLKS_PER_BIT / 2) @(negedge clock); // centre of start bit
			for (int b = 0; b < 8; b++) begin
				repeat (CLKS_PER_BIT) @(negedge clock);
				data[b] = tx; // lsb first
			end
			repeat (CLKS_PER_BIT) @(negedge clock);
			ok = (tx === 1'b1);
			assert (ok) else begin
				$display("stop bit on tx was low, time %0t", $time);
				error_count++;
			end
		end
	endtask

	task automatic check_line(input count_t count, input count_t width);
		bit ok;
		byte_t got;
		byte_t want;
		ok = 1'b1;
		for (int i = 0; (i < LINE_LENGTH) && ok; i++) begin
			receive_byte((i == 0) ? LINE_WAIT : CHAR_WAIT, got, ok);
			want = expected_char(count, width, i);
			if (ok) begin
				assert (got === want) else begin
					$display("Mismatch at %0t: tx char %0d expected %h got %h",
						$time, i, want, got);
					error_count++;
				end
			end
		end
	endtask

	// tx must stay idle for the given number of cycles
	task automatic check_quiet(input int cycles);
		bit low_seen;
		low_seen = 1'b0;
		for (int i = 0; (i < cycles) && !low_seen; i++) begin
			@(negedge clock);
			low_seen = (tx !== 1'b1);
		end
		assert (!low_seen) else begin
			$display("Mismatch at %0t: tx expected 1 got %b", $time, tx);
			error_count++;
		end
	endtask

	task automatic wait_for_phase(input int phase);
		int waited;
		waited = 0;
		@(negedge clock);
		while (((cycle_count % REPORT_PERIOD) != phase) && (waited < 2 * REPORT_PERIOD)) begin
			@(negedge clock);
			waited++;
		end
		assert ((cycle_count % REPORT_PERIOD) == phase) else begin
			$display("report timer phase %0d not reached, time %0t", phase, $time);
			error_count++;
		end
	endtask

	task automatic close_test(input string name, input int errors_before);
		if (error_count != errors_before) tests_with_errors++;
		$display("test %s: %0d errors", name, error_count - errors_before);
	endtask

	task automatic test_quiet_after_reset();
		int errors_before;
		errors_before = error_count;
		check_quiet(3 * REPORT_PERIOD); // count still zero
		close_test("quiet after reset", errors_before);
	endtask

	task automatic test_single_pulse();
		int errors_before;
		errors_before = error_count;
		send_pulse(37, 8);
		check_line(16'd1, 16'd37); // 00001 00037
		close_test("single pulse", errors_before);
	endtask

	task automatic test_burst();
		int errors_before;
		int width;
		int gap;
		errors_before = error_count;
		wait_for_phase(32); // just past a wrap so the burst ends before the next
		for (int p = 0; p < 5; p++) begin
			draw_random(1, 300, width);
			draw_random(4, 200, gap);
			send_pulse(width, gap);
		end
		check_line(model_count, model_width);
		close_test("burst of pulses", errors_before);
	endtask

	task automatic test_no_repeat();
		int errors_before;
		errors_before = error_count;
		check_quiet(2 * REPORT_PERIOD); // no new pulses, no new line
		close_test("no repeat", errors_before);
	endtask

	task automatic test_pulses_during_line();
		int errors_before;
		int width;
		int gap;
		bit started;
		count_t first_count;
		count_t first_width;
		errors_before = error_count;
		draw_random(1, 300, width);
		send_pulse(width, 8);
		first_count = model_count; // snapshot the line will carry
		first_width = model_width;
		fork
			check_line(first_count, first_width);
			begin
				wait_tx_low(LINE_WAIT, started);
				if (started) begin
					for (int p = 0; p < 3; p++) begin
						draw_random(1, 100, width);
						draw_random(4, 50, gap);
						send_pulse(width, gap);
					end
				end
			end
		join
		check_line(model_count, model_width); // late pulses show up here
		close_test("pulses during transmission", errors_before);
	endtask

	initial begin
		int waited;
		trigger = 1'b0;
		waited = 0;
		while ((reset !== 1'b0) && (waited < 100)) begin
			@(negedge clock);
			waited++;
		end
		assert (reset === 1'b0) else begin
			$display("reset never released, time %0t", $time);
			error_count++;
		end
		test_quiet_after_reset();
		test_single_pulse();
		test_burst();
		test_no_repeat();
		test_pulses_during_line();
		$display("tests 5, tests with errors %0d, total errors %0d",
			tests_with_errors, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench clock, period 10, reset high for the first 8 rising edges
////////////////////////////////////////////////////////////////////////////
module tb_clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 time units per cycle
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0; // released on a rising edge like any other input
	end

endmodule

// ==== verilog.f ====
rtl/pulse_meter_pkg.sv
rtl/bcd_if.sv
rtl/pulse_meter.sv
rtl/bin_to_bcd.sv
rtl/report_formatter.sv
rtl/uart_tx.sv
rtl/pulse_reporter_top.sv
sim/tb_clock_gen.sv
sim/pulse_reporter_tb.sv
